// ==== run.sh ====
#!/bin/sh
# build the data cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_dcache -o tb_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

echo "simulation exited cleanly"
exit 0

// ==== source/dcache_ctrl.sv ====
// dcache_ctrl: cache FSM for lookup, read refill, write-through and the memory handshake
module dcache_ctrl (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                req_valid,
    output logic                                req_ready,
    output logic                                buf_we,
    input  logic                                write,
    input  dcache_pkg::dcache_addr_u            addr,
    input  logic [dcache_pkg::word_width-1:0]   wdata,
    input  logic [dcache_pkg::strb_width-1:0]   wstrb,
    input  logic                                hit0,
    input  logic                                hit1,
    input  dcache_pkg::way_t                    victim,
    output logic [1:0]                          way_we,
    output logic                                replace,
    output logic                                use0,
    output logic                                use1,
    input  logic [dcache_pkg::word_width-1:0]   rword0,
    input  logic [dcache_pkg::word_width-1:0]   rword1,
    output logic                                resp_valid,
    output logic [dcache_pkg::word_width-1:0]   resp_rdata,
    output logic                                mem_req,
    output logic                                mem_wr,
    output logic [31:0]                         mem_addr,
    output logic [dcache_pkg::word_width-1:0]   mem_wdata,
    output logic [dcache_pkg::strb_width-1:0]   mem_wstrb,
    input  logic                                mem_addr_ok,
    input  logic                                mem_data_ok,
    input  logic [dcache_pkg::line_width-1:0]   mem_rdata
);
    import dcache_pkg::*;

    localparam logic [2:0] st_idle        = 3'd0;
    localparam logic [2:0] st_lookup      = 3'd1;
    localparam logic [2:0] st_miss_r      = 3'd2;
    localparam logic [2:0] st_miss_r_wait = 3'd3;
    localparam logic [2:0] st_miss_w      = 3'd4;
    localparam logic [2:0] st_hit_w       = 3'd5;

    logic [2:0]   state;
    logic [2:0]   next_state;
    logic         done;
    dcache_addr_u line_addr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////
    // memory side
    ////////////////////////////////////////
    // refill reads fetch from the start of the line
    always_comb begin
        line_addr            = addr;
        line_addr.f.word     = '0;
        line_addr.f.byte_off = '0;
    end

    assign mem_addr  = mem_wr ? addr.raw : line_addr.raw;
    assign mem_wdata = wdata;
    assign mem_wstrb = wstrb;

    ////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////
    always_comb begin
        next_state = state;
        done       = 1'b0;
        req_ready  = 1'b0;
        buf_we     = 1'b0;
        way_we     = 2'b00;
        replace    = 1'b0;
        use0       = 1'b0;
        use1       = 1'b0;
        resp_valid = 1'b0;
        resp_rdata = '0;
        mem_req    = 1'b0;
        mem_wr     = 1'b0;
        case (state)
            st_idle: begin
                done = 1'b1;
            end
            st_lookup: begin
                if ((hit0 || hit1) && !write) begin
                    resp_valid = 1'b1;
                    resp_rdata = hit0 ? rword0 : rword1;
                    use0       = hit0;
                    use1       = !hit0;
                    done       = 1'b1;
                end else if (hit0 || hit1) begin
                    // cache copy updated now, memory copy via write-through
                    way_we  = {!hit0, hit0};
                    use0    = hit0;
                    use1    = !hit0;
                    mem_req = 1'b1;
                    mem_wr  = 1'b1;
                    if (mem_addr_ok) begin
                        done = 1'b1;
                    end else begin
                        next_state = st_hit_w;
                    end
                end else if (!write) begin
                    mem_req    = 1'b1;
                    next_state = mem_addr_ok ? st_miss_r_wait : st_miss_r;
                end else begin
                    // no allocate, word goes to memory only
                    mem_req = 1'b1;
                    mem_wr  = 1'b1;
                    if (mem_addr_ok) begin
                        done = 1'b1;
                    end else begin
                        next_state = st_miss_w;
                    end
                end
            end
            st_miss_r: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    next_state = st_miss_r_wait;
                end
            end
            st_miss_r_wait: begin
                if (mem_data_ok) begin
                    replace        = 1'b1;
                    way_we[victim] = 1'b1;
                    use0           = (victim == 1'b0);
                    use1           = (victim == 1'b1);
                    resp_valid     = 1'b1;
                    resp_rdata     = mem_rdata[addr.f.word*word_width +: word_width];
                    done           = 1'b1;
                end
            end
            st_miss_w, st_hit_w: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                if (mem_addr_ok) begin
                    done = 1'b1;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase

        // last cycle of an operation, a new request may be taken here
        if (done) begin
            req_ready  = 1'b1;
            buf_we     = req_valid;
            next_state = req_valid ? st_lookup : st_idle;
        end
    end

    // tags of one set never match in both ways
    a_one_hit: assert property (@(posedge clk) disable iff (!rstn) !(hit0 && hit1));

    // request held with a stable address until the memory takes it
    a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_addr));

endmodule

// ==== source/dcache_lru.sv ====
// dcache_lru: one bit per set naming the least recently used of the two ways
module dcache_lru (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic [dcache_pkg::index_width-1:0]  index,
    input  logic                                use0,
    input  logic                                use1,
    output dcache_pkg::way_t                    victim
);
    import dcache_pkg::*;

    // bit set means way 1 is the older one
    logic [num_sets-1:0] lru_bits;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_bits <= '0;
        end else if (use0) begin
            lru_bits[index] <= 1'b1;
        end else if (use1) begin
            lru_bits[index] <= 1'b0;
        end
    end

    assign victim = lru_bits[index];

    // controller marks at most one way per cycle
    a_single_use: assert property (@(posedge clk) disable iff (!rstn) !(use0 && use1));

endmodule

// ==== source/dcache_pkg.sv ====
// dcache_pkg: shared geometry, widths and address layout of the two-way data cache
package dcache_pkg;

    ////////////////////////////////////////
    // geometry
    ////////////////////////////////////////
    localparam int word_width     = 32;
    localparam int index_width    = 4;
    localparam int offset_width   = 2;
    localparam int byte_width     = 2;
    localparam int words_per_line = 1 << offset_width;
    localparam int num_sets       = 1 << index_width;
    localparam int line_width     = word_width * words_per_line;
    localparam int strb_width     = word_width / 8;
    localparam int tag_width      = 32 - index_width - offset_width - byte_width;

    ////////////////////////////////////////
    // address views
    ////////////////////////////////////////
    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] word;
        logic [byte_width-1:0]   byte_off;
    } dcache_addr_f_t;

    // same 32 bits, either as the bus word or split into fields
    typedef union packed {
        logic [31:0]    raw;
        dcache_addr_f_t f;
    } dcache_addr_u;

    // two ways, so one bit names a way
    typedef logic way_t;

endpackage

// ==== source/dcache_req_buffer.sv ====
// dcache_req_buffer: holds the accepted core request while the cache works on it
module dcache_req_buffer (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                buf_we,
    input  dcache_pkg::dcache_addr_u            in_addr,
    input  logic [dcache_pkg::word_width-1:0]   in_wdata,
    input  logic [dcache_pkg::strb_width-1:0]   in_wstrb,
    input  logic                                in_write,
    output dcache_pkg::dcache_addr_u            addr,
    output logic [dcache_pkg::word_width-1:0]   wdata,
    output logic [dcache_pkg::strb_width-1:0]   wstrb,
    output logic                                write
);

    // capture on the accepting edge, the core is free to move on after it
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            // idle read of address zero
            addr.raw <= '0;
            wdata    <= '0;
            wstrb    <= '0;
            write    <= 1'b0;
        end else if (buf_we) begin
            addr  <= in_addr;
            wdata <= in_wdata;
            wstrb <= in_wstrb;
            write <= in_write;
        end
    end

endmodule

// ==== source/dcache_top.sv ====
// dcache_top: two-way write-through data cache, request buffer, ways, LRU and controller
module dcache_top (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                req_valid,
    input  logic                                req_write,
    input  logic [31:0]                         req_addr,
    input  logic [dcache_pkg::word_width-1:0]   req_wdata,
    input  logic [dcache_pkg::strb_width-1:0]   req_wstrb,
    output logic                                req_ready,
    output logic                                resp_valid,
    output logic [dcache_pkg::word_width-1:0]   resp_rdata,
    output logic                                mem_req,
    output logic                                mem_wr,
    output logic [31:0]                         mem_addr,
    output logic [dcache_pkg::word_width-1:0]   mem_wdata,
    output logic [dcache_pkg::strb_width-1:0]   mem_wstrb,
    input  logic                                mem_addr_ok,
    input  logic                                mem_data_ok,
    input  logic [dcache_pkg::line_width-1:0]   mem_rdata
);
    import dcache_pkg::*;

    logic                  buf_we;
    dcache_addr_u          buf_addr;
    logic [word_width-1:0] buf_wdata;
    logic [strb_width-1:0] buf_wstrb;
    logic                  buf_write;
    logic                  hit0;
    logic                  hit1;
    logic [word_width-1:0] rword0;
    logic [word_width-1:0] rword1;
    way_t                  victim;
    logic [1:0]            way_we;
    logic                  replace;
    logic                  use0;
    logic                  use1;

    dcache_req_buffer i_req_buffer (
        .clk(clk), .rstn(rstn), .buf_we(buf_we),
        .in_addr(req_addr), .in_wdata(req_wdata), .in_wstrb(req_wstrb), .in_write(req_write),
        .addr(buf_addr), .wdata(buf_wdata), .wstrb(buf_wstrb), .write(buf_write)
    );

    dcache_way i_way0 (
        .clk(clk), .rstn(rstn), .addr(buf_addr), .wdata(buf_wdata), .wstrb(buf_wstrb),
        .we(way_we[0]), .replace(replace), .refill_line(mem_rdata),
        .hit(hit0), .rword(rword0)
    );

    dcache_way i_way1 (
        .clk(clk), .rstn(rstn), .addr(buf_addr), .wdata(buf_wdata), .wstrb(buf_wstrb),
        .we(way_we[1]), .replace(replace), .refill_line(mem_rdata),
        .hit(hit1), .rword(rword1)
    );

    dcache_lru i_lru (
        .clk(clk), .rstn(rstn), .index(buf_addr.f.index),
        .use0(use0), .use1(use1), .victim(victim)
    );

    dcache_ctrl i_ctrl (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .req_ready(req_ready), .buf_we(buf_we),
        .write(buf_write), .addr(buf_addr), .wdata(buf_wdata), .wstrb(buf_wstrb),
        .hit0(hit0), .hit1(hit1), .victim(victim), .way_we(way_we), .replace(replace),
        .use0(use0), .use1(use1), .rword0(rword0), .rword1(rword1),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata)
    );

endmodule

// ==== source/dcache_way.sv ====
// dcache_way: valid, tag and line storage of one cache way with lookup and byte-merged writes
module dcache_way (
    input  logic                                clk,
    input  logic                                rstn,
    input  dcache_pkg::dcache_addr_u            addr,
    input  logic [dcache_pkg::word_width-1:0]   wdata,
    input  logic [dcache_pkg::strb_width-1:0]   wstrb,
    input  logic                                we,
    input  logic                                replace,
    input  logic [dcache_pkg::line_width-1:0]   refill_line,
    output logic                                hit,
    output logic [dcache_pkg::word_width-1:0]   rword
);
    import dcache_pkg::*;

    logic [num_sets-1:0]   valid;
    logic [tag_width-1:0]  tag_mem [num_sets];
    logic [line_width-1:0] data_mem [num_sets];
    logic [line_width-1:0] cur_line;
    logic [line_width-1:0] merged_line;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////
    assign cur_line = data_mem[addr.f.index];
    assign hit      = valid[addr.f.index] && (tag_mem[addr.f.index] == addr.f.tag);
    assign rword    = cur_line[addr.f.word*word_width +: word_width];

    // store hit: only the strobed bytes of the addressed word change
    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < strb_width; b++) begin
            if (wstrb[b]) begin
                merged_line[addr.f.word*word_width + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // update
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (we && replace) begin
            valid[addr.f.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            if (replace) begin
                // refill, the whole line and its tag at once
                tag_mem[addr.f.index]  <= addr.f.tag;
                data_mem[addr.f.index] <= refill_line;
            end else begin
                data_mem[addr.f.index] <= merged_line;
            end
        end
    end

endmodule

// ==== sources.f ====
source/dcache_pkg.sv
source/dcache_req_buffer.sv
source/dcache_way.sv
source/dcache_lru.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tests/tb_clock.sv
tests/tb_mem.sv
tests/tb_dcache.sv

// ==== tests/tb_clock.sv ====
// tb_clock: free-running clock for the cache testbench
module tb_clock #(
    parameter int period_ns = 20
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

// ==== tests/tb_dcache.sv ====
// tb_dcache runs directed and random tests of the two-way write-through data cache
module tb_dcache;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 10;
    localparam int random_ops   = 200;
    localparam int max_requests = random_ops + 40;
    localparam int max_delay    = 9;
    localparam int line_bytes   = line_width / 8;
    // worst request takes both memory delays plus handshake and lookup cycles
    localparam int timeout_ns   = (reset_cycles + max_requests * (2 * max_delay + 6)) * clk_period;

    logic                  clk;
    logic                  rstn;
    logic                  req_valid;
    logic                  req_write;
    logic [31:0]           req_addr;
    logic [word_width-1:0] req_wdata;
    logic [strb_width-1:0] req_wstrb;
    logic                  req_ready;
    logic                  resp_valid;
    logic [word_width-1:0] resp_rdata;
    logic                  mem_req;
    logic                  mem_wr;
    logic [31:0]           mem_addr;
    logic [word_width-1:0] mem_wdata;
    logic [strb_width-1:0] mem_wstrb;
    logic                  mem_addr_ok;
    logic                  mem_data_ok;
    logic [line_width-1:0] mem_rdata;
    int                    addr_delay;
    int                    data_delay;
    int                    rd_count;
    int                    wr_count;
    logic [strb_width-1:0] last_wstrb;
    logic [31:0]           last_addr;
    logic [word_width-1:0] ref_mem [1024];
    int                    seed = 32'h2481_c575;

    tb_clock #(.period_ns(clk_period)) i_clock (.clk(clk));

    tb_mem i_mem (
        .clk(clk), .rstn(rstn), .addr_delay(addr_delay), .data_delay(data_delay),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata),
        .rd_count(rd_count), .wr_count(wr_count), .last_wstrb(last_wstrb),
        .last_addr(last_addr)
    );

    dcache_top i_dut (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_wstrb(req_wstrb),
        .req_ready(req_ready), .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [word_width-1:0] fill_word(input int idx);
        return idx * 32'h9e37_79b9 ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int index, input int word);
        dcache_addr_u a;
        a.raw     = '0;
        a.f.tag   = tag_width'(tag);
        a.f.index = index_width'(index);
        a.f.word  = offset_width'(word);
        return a.raw;
    endfunction

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [word_width-1:0] got,
                              input logic [word_width-1:0] exp);
        if (got !== exp) begin
            $display("ERROR: time %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR: time %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_strobes(input string name, input logic [strb_width-1:0] got,
                                 input logic [strb_width-1:0] exp);
        if (got !== exp) begin
            $display("ERROR: time %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: time %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // one core request with its read data and the cycles from acceptance to the end
    task automatic access(input logic wr, input logic [31:0] addr,
                          input logic [word_width-1:0] wdata, input logic [strb_width-1:0] wstrb,
                          output logic [word_width-1:0] rdata, output int latency);
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_wstrb <= wstrb;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        req_valid <= 1'b0;
        latency = 0;
        rdata   = '0;
        do begin
            @(negedge clk);
            latency++;
            if (!wr && req_ready && !resp_valid) begin
                $display("req_ready went high at %0t before the read response", $time);
                stop_run();
            end
            if (wr && resp_valid) begin
                $display("resp_valid strobed at %0t during a write", $time);
                stop_run();
            end
        end while (wr ? !req_ready : !resp_valid);
        if (!wr) begin
            rdata = resp_rdata;
        end
    endtask

    // a negative exp_reads skips the memory read count
    task automatic read_check(input logic [31:0] addr, input int exp_reads, output int latency);
        int                    rd_before;
        logic [word_width-1:0] data;
        rd_before = rd_count;
        access(1'b0, addr, '0, '0, data, latency);
        check_word("resp_rdata", data, ref_mem[addr[11:2]]);
        if (exp_reads >= 0) begin
            check_count("memory reads", rd_count - rd_before, exp_reads);
        end
        if (rd_count != rd_before) begin
            // refill reads start at the first byte of the line
            check_addr("mem_addr", last_addr, addr & ~32'(line_bytes - 1));
        end
    endtask

    task automatic write_check(input logic [31:0] addr, input logic [word_width-1:0] data,
                               input logic [strb_width-1:0] strb);
        int                    rd_before;
        int                    wr_before;
        int                    latency;
        logic [word_width-1:0] unused;
        rd_before = rd_count;
        wr_before = wr_count;
        access(1'b1, addr, data, strb, unused, latency);
        // memory counts the write on the edge that ends the operation
        @(negedge clk);
        for (int b = 0; b < strb_width; b++) begin
            if (strb[b]) begin
                ref_mem[addr[11:2]][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        check_count("memory writes", wr_count - wr_before, 1);
        check_count("memory reads", rd_count - rd_before, 0);
        check_strobes("mem_wstrb", last_wstrb, strb);
        check_addr("mem_addr", last_addr, addr);
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic read_miss_then_hit();
        int latency;
        read_check(make_addr(1, 2, 1), 1, latency);
        read_check(make_addr(1, 2, 1), 0, latency);
        check_count("read hit latency", latency, 1);
    endtask

    task automatic write_hit_through();
        int latency;
        write_check(make_addr(1, 2, 3), 32'hdead_beef, 4'b0101);
        read_check(make_addr(1, 2, 3), 0, latency);
    endtask

    task automatic write_miss_no_alloc();
        int latency;
        write_check(make_addr(5, 7, 0), 32'h1234_5678, 4'b1100);
        read_check(make_addr(5, 7, 0), 1, latency);
        read_check(make_addr(5, 7, 2), 0, latency);
    endtask

    // A, B and C share set 9
    task automatic lru_replacement();
        int latency;
        read_check(make_addr(2, 9, 0), 1, latency);
        read_check(make_addr(3, 9, 0), 1, latency);
        read_check(make_addr(2, 9, 0), 0, latency);
        read_check(make_addr(4, 9, 0), 1, latency);
        read_check(make_addr(2, 9, 0), 0, latency);
        read_check(make_addr(3, 9, 0), 1, latency);
    endtask

    task automatic back_pressure();
        int latency;
        addr_delay <= 6;
        data_delay <= max_delay;
        read_check(make_addr(6, 11, 2), 1, latency);
        read_check(make_addr(6, 11, 2), 0, latency);
        check_count("read hit latency", latency, 1);
        write_check(make_addr(6, 11, 0), 32'h0bad_f00d, 4'b1111);
        addr_delay <= 0;
        data_delay <= 0;
    endtask

    task automatic random_mix();
        int          r;
        int          latency;
        logic [31:0] addr;
        for (int i = 0; i < random_ops; i++) begin
            r = $random(seed);
            addr_delay <= (r >> 16) & 3;
            data_delay <= (r >> 18) & 3;
            addr = make_addr(8 + ((r >> 4) & 3), (r >> 6) & 3, (r >> 8) & 3);
            if (r[0]) begin
                write_check(addr, $random(seed), strb_width'(r >> 12));
            end else begin
                read_check(addr, -1, latency);
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////
    initial begin
        req_valid  <= 1'b0;
        req_write  <= 1'b0;
        req_addr   <= '0;
        req_wdata  <= '0;
        req_wstrb  <= '0;
        addr_delay <= 0;
        data_delay <= 0;
        rstn       <= 1'b0;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = fill_word(i);
        end
        repeat (reset_cycles) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        if (!req_ready || mem_req || resp_valid) begin
            $display("cache not idle after reset at %0t", $time);
            stop_run();
        end
        read_miss_then_hit();
        write_hit_through();
        write_miss_no_alloc();
        lru_replacement();
        back_pressure();
        random_mix();
        $display("test passed");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("timeout after %0d ns with tests still running", timeout_ns);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== tests/tb_mem.sv ====
// tb_mem models the line memory behind the cache with programmable handshake delays and request counters
module tb_mem (
    input  logic                                clk,
    input  logic                                rstn,
    input  int                                  addr_delay,
    input  int                                  data_delay,
    input  logic                                mem_req,
    input  logic                                mem_wr,
    input  logic [31:0]                         mem_addr,
    input  logic [dcache_pkg::word_width-1:0]   mem_wdata,
    input  logic [dcache_pkg::strb_width-1:0]   mem_wstrb,
    output logic                                mem_addr_ok,
    output logic                                mem_data_ok,
    output logic [dcache_pkg::line_width-1:0]   mem_rdata,
    output int                                  rd_count,
    output int                                  wr_count,
    output logic [dcache_pkg::strb_width-1:0]   last_wstrb,
    output logic [31:0]                         last_addr
);
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    logic [word_width-1:0] words [1024];
    int                    addr_wait;
    int                    data_wait;
    logic                  rd_pending;
    logic [7:0]            pend_line;

    // start-up contents differ at every word address
    function automatic logic [word_width-1:0] fill_word(input int idx);
        return idx * 32'h9e37_79b9 ^ 32'h5bd1_e995;
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            words[i] = fill_word(i);
        end
    end

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
            rd_count    <= 0;
            wr_count    <= 0;
            last_wstrb  <= '0;
            last_addr   <= '0;
            addr_wait   <= 0;
            data_wait   <= 0;
            rd_pending  <= 1'b0;
            pend_line   <= '0;
        end else begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            if (mem_req && mem_addr_ok) begin
                // request taken in this cycle
                addr_wait <= 0;
                last_addr <= mem_addr;
                if (mem_wr) begin
                    wr_count   <= wr_count + 1;
                    last_wstrb <= mem_wstrb;
                    for (int b = 0; b < strb_width; b++) begin
                        if (mem_wstrb[b]) begin
                            words[mem_addr[11:2]][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                        end
                    end
                end else begin
                    rd_count   <= rd_count + 1;
                    rd_pending <= 1'b1;
                    data_wait  <= 0;
                    pend_line  <= mem_addr[11:4];
                end
            end else if (mem_req) begin
                if (addr_wait >= addr_delay) begin
                    mem_addr_ok <= 1'b1;
                end else begin
                    addr_wait <= addr_wait + 1;
                end
            end
            // read data comes as one line in a single beat
            if (rd_pending) begin
                if (data_wait >= data_delay) begin
                    mem_data_ok <= 1'b1;
                    rd_pending  <= 1'b0;
                    for (int w = 0; w < words_per_line; w++) begin
                        mem_rdata[w*word_width +: word_width] <= words[{pend_line, w[1:0]}];
                    end
                end else begin
                    data_wait <= data_wait + 1;
                end
            end
        end
    end

endmodule
